/* sim.f */
+incdir+src
src/sample_pkg.sv
src/fit_pkg.sv
src/moment_accum.sv
src/seq_divider.sv
src/line_solver.sv
src/line_fit_top.sv
bench/line_fit_tb.sv

/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      ?= line_fit_tb
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/line_fit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fit_defs.svh"

module line_fit_tb
  import sample_pkg::*;
  import fit_pkg::*;
();

  localparam int DIV_W          = `FIT_DIV_W;
  localparam int FRAC           = `FIT_SLOPE_FRAC;
  localparam int NUM_FITS       = 30;
  localparam int MAX_POINTS     = 64;
  // every fit is at most its points, the divide and a few cycles of handshake
  localparam int TIMEOUT_CYCLES = NUM_FITS * (MAX_POINTS + DIV_W + 10);
  // tabulate edge to fit_valid
  localparam int LAT_FIT        = DIV_W + 3;
  localparam int LAT_DEGEN      = 2;

  logic       clk_in;
  logic       rst_in;
  logic       point_valid;
  x_t         point_x;
  y_t         point_y;
  logic       tabulate;
  logic       busy;
  logic       fit_valid;
  slope_t     fit_slope;
  intercept_t fit_intercept;
  logic       fit_error;

  int cycle = 0;
  int pass_count = 0;
  int fail_count = 0;
  int test_errors = 0;
  // current point set
  int set_x[$];
  int set_y[$];

  line_fit_top dut0 (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .point_valid   (point_valid),
    .point_x       (point_x),
    .point_y       (point_y),
    .tabulate      (tabulate),
    .busy          (busy),
    .fit_valid     (fit_valid),
    .fit_slope     (fit_slope),
    .fit_intercept (fit_intercept),
    .fit_error     (fit_error)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  // cycle count, also the run limit
  always @(posedge clk_in) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // least-squares reference in 64-bit integers, division truncates toward zero
  task automatic model_fit(output logic err, output slope_t slope, output intercept_t icpt);
    longint n;
    longint sx;
    longint sy;
    longint sxy;
    longint sxx;
    longint num_m;
    longint num_b;
    longint den;
    n = longint'(set_x.size());
    sx = 0;
    sy = 0;
    sxy = 0;
    sxx = 0;
    foreach (set_x[i]) begin
      sx  += longint'(set_x[i]);
      sy  += longint'(set_y[i]);
      sxy += longint'(set_x[i]) * longint'(set_y[i]);
      sxx += longint'(set_x[i]) * longint'(set_x[i]);
    end
    num_m = n * sxy - sx * sy;
    num_b = sy * sxx - sx * sxy;
    den   = n * sxx - sx * sx;
    if (den == 0) begin
      err   = 1'b1;
      slope = '0;
      icpt  = '0;
    end else begin
      err   = 1'b0;
      slope = slope_t'((num_m * (longint'(1) << FRAC)) / den);
      icpt  = intercept_t'(num_b / den);
    end
  endtask

  task automatic check_slope(string name, slope_t exp, slope_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s slope: expected %0d, actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_intercept(string name, intercept_t exp, intercept_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s intercept: expected %0d, actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(string name, string what, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (act != exp) begin
      $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("ok   %s", name);
    end else begin
      fail_count++;
      $display("bad  %s, %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  // junk on the inputs while the solver is busy
  task automatic drive_noise();
    point_valid = ($urandom % 2) != 0;
    point_x     = x_t'($urandom);
    point_y     = y_t'($urandom);
    tabulate    = ($urandom % 3) == 0;
  endtask

  // feed the set, tabulate, wait for the result and compare
  task automatic run_fit(string name, bit noisy, logic exp_err, slope_t exp_slope,
                         intercept_t exp_icpt);
    int tab_edge;
    foreach (set_x[i]) begin
      point_valid = 1'b1;
      point_x     = x_t'(set_x[i]);
      point_y     = y_t'(set_y[i]);
      @(posedge clk_in);
      #1;
    end
    point_valid = 1'b0;
    tabulate    = 1'b1;
    @(posedge clk_in);
    #1;
    tabulate = 1'b0;
    tab_edge = cycle;
    check_flag(name, "busy after tabulate", 1'b1, busy);
    while (!fit_valid) begin
      if (noisy) begin
        drive_noise();
      end
      @(posedge clk_in);
      #1;
    end
    point_valid = 1'b0;
    tabulate    = 1'b0;
    check_latency(name, exp_err ? LAT_DEGEN : LAT_FIT, cycle - tab_edge);
    check_flag(name, "fit_error", exp_err, fit_error);
    check_slope(name, exp_slope, fit_slope);
    check_intercept(name, exp_icpt, fit_intercept);
    // report cycle is still busy, idle again one edge later
    @(posedge clk_in);
    #1;
    check_flag(name, "fit_valid after result", 1'b0, fit_valid);
    check_flag(name, "busy after result", 1'b0, busy);
    finish_test(name);
  endtask

  initial begin
    int         n;
    int         k;
    int         c;
    int         x;
    string      name;
    logic       e;
    slope_t     es;
    intercept_t ei;
    void'($urandom(32'he87f));
    rst_in      = 1'b1;
    point_valid = 1'b0;
    point_x     = '0;
    point_y     = '0;
    tabulate    = 1'b0;
    repeat (2) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    // empty set straight out of reset
    check_flag("reset_empty", "fit_valid", 1'b0, fit_valid);
    check_flag("reset_empty", "busy", 1'b0, busy);
    set_x.delete();
    set_y.delete();
    run_fit("reset_empty", 1'b0, 1'b1, '0, '0);

    // points exactly on y = k*x + c, x kept below 200
    for (int t = 0; t < 6; t++) begin
      n = rand_range(3, 40);
      k = rand_range(-4, 4);
      if (k >= 0) begin
        c = rand_range(0, 1023 - k * 199);
      end else begin
        c = rand_range(-k * 199, 1023);
      end
      set_x.delete();
      set_y.delete();
      for (int i = 0; i < n; i++) begin
        // first two x values differ, so the line is defined
        if (i == 0) begin
          x = rand_range(0, 99);
        end else if (i == 1) begin
          x = rand_range(100, 199);
        end else begin
          x = rand_range(0, 199);
        end
        set_x.push_back(x);
        set_y.push_back(k * x + c);
      end
      name = $sformatf("exact_line_%0d", t);
      run_fit(name, 1'b0, 1'b0, slope_t'(k * (1 << FRAC)), intercept_t'(c));
    end

    // random clouds over the whole frame
    for (int t = 0; t < 12; t++) begin
      n = rand_range(2, MAX_POINTS);
      set_x.delete();
      set_y.delete();
      for (int i = 0; i < n; i++) begin
        set_x.push_back(rand_range(0, 2047));
        set_y.push_back(rand_range(0, 1023));
      end
      model_fit(e, es, ei);
      name = $sformatf("random_cloud_%0d", t);
      run_fit(name, 1'b0, e, es, ei);
    end

    // one point, then vertical sets
    for (int t = 0; t < 4; t++) begin
      n = (t == 0) ? 1 : rand_range(2, MAX_POINTS);
      x = rand_range(0, 2047);
      set_x.delete();
      set_y.delete();
      for (int i = 0; i < n; i++) begin
        set_x.push_back(x);
        set_y.push_back(rand_range(0, 1023));
      end
      name = $sformatf("degenerate_%0d", t);
      run_fit(name, 1'b0, 1'b1, '0, '0);
    end

    // input junk during the divide must not leak into the result
    for (int t = 0; t < 3; t++) begin
      n = rand_range(2, MAX_POINTS);
      set_x.delete();
      set_y.delete();
      for (int i = 0; i < n; i++) begin
        set_x.push_back(rand_range(0, 2047));
        set_y.push_back(rand_range(0, 1023));
      end
      model_fit(e, es, ei);
      name = $sformatf("busy_noise_%0d", t);
      run_fit(name, 1'b1, e, es, ei);
    end

    // small sets with no gap, each must see only its own points
    for (int t = 0; t < 4; t++) begin
      n = rand_range(2, 16);
      set_x.delete();
      set_y.delete();
      for (int i = 0; i < n; i++) begin
        set_x.push_back(rand_range(0, 2047));
        set_y.push_back(rand_range(0, 1023));
      end
      model_fit(e, es, ei);
      name = $sformatf("consecutive_%0d", t);
      run_fit(name, 1'b0, e, es, ei);
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/line_fit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module line_fit_top
  import sample_pkg::*;
  import fit_pkg::*;
(
  input  wire logic   clk_in,
  input  wire logic   rst_in,
  input  wire logic   point_valid,
  input  wire x_t     point_x,
  input  wire y_t     point_y,
  input  wire logic   tabulate,
  output logic        busy,
  output logic        fit_valid,
  output slope_t      fit_slope,
  output intercept_t  fit_intercept,
  output logic        fit_error
);

  // moments handed from accumulator to solver
  count_t  count;
  sum_x_t  sum_x;
  sum_y_t  sum_y;
  sum_xy_t sum_xy;
  sum_xx_t sum_xx;
  logic    sums_clear;

  // accumulator holds off points while the solver is busy
  moment_accum u_accum (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .point_valid (point_valid),
    .point_x     (point_x),
    .point_y     (point_y),
    .hold        (busy),
    .sums_clear  (sums_clear),
    .count       (count),
    .sum_x       (sum_x),
    .sum_y       (sum_y),
    .sum_xy      (sum_xy),
    .sum_xx      (sum_xx)
  );

  line_solver u_solver (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .tabulate      (tabulate),
    .point_valid   (point_valid),
    .count         (count),
    .sum_x         (sum_x),
    .sum_y         (sum_y),
    .sum_xy        (sum_xy),
    .sum_xx        (sum_xx),
    .solve_busy    (busy),
    .sums_clear    (sums_clear),
    .fit_valid     (fit_valid),
    .fit_slope     (fit_slope),
    .fit_intercept (fit_intercept),
    .fit_error     (fit_error)
  );

endmodule

`default_nettype wire

/* src/line_solver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fit_defs.svh"

module line_solver
  import sample_pkg::*;
  import fit_pkg::*;
(
  input  wire logic    clk_in,
  input  wire logic    rst_in,
  input  wire logic    tabulate,
  input  wire logic    point_valid,
  input  wire count_t  count,
  input  wire sum_x_t  sum_x,
  input  wire sum_y_t  sum_y,
  input  wire sum_xy_t sum_xy,
  input  wire sum_xx_t sum_xx,
  output logic         solve_busy,
  output logic         sums_clear,
  output logic         fit_valid,
  output slope_t       fit_slope,
  output intercept_t   fit_intercept,
  output logic         fit_error
);

  localparam int DW = `FIT_DIV_W;

  typedef logic [DW-1:0]        wide_t;
  typedef logic signed [DW-1:0] wide_s_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FORM,
    ST_LAUNCH,
    ST_WAIT,
    ST_REPORT
  } state_t;

  state_t         state;
  // signed numerators and denominator, every term fits well inside DW
  wide_s_t        slope_num;
  wide_s_t        icpt_num;
  wide_s_t        denom;
  wide_t          slope_abs;
  wide_t          icpt_abs;
  wide_t          denom_abs;
  logic           slope_neg;
  logic           icpt_neg;
  logic           denom_zero;
  logic           tab_accept;
  logic           div_start;
  logic           slope_done;
  logic           icpt_done;
  logic           slope_running;
  logic           icpt_running;
  slope_mag_t     slope_q;
  intercept_mag_t icpt_q;

  // a point on the same cycle wins over tabulate
  assign tab_accept = tabulate && !point_valid && !solve_busy;
  assign solve_busy = (state != ST_IDLE) || slope_running || icpt_running;

  assign slope_abs  = slope_num[DW-1] ? wide_t'(-slope_num) : wide_t'(slope_num);
  assign icpt_abs   = icpt_num[DW-1] ? wide_t'(-icpt_num) : wide_t'(icpt_num);
  assign denom_abs  = denom[DW-1] ? wide_t'(-denom) : wide_t'(denom);
  assign denom_zero = (denom == '0);
  assign div_start  = (state == ST_LAUNCH) && !denom_zero;

  // numerator terms, wrap in unsigned math then read back as signed
  always_ff @(posedge clk_in) begin
    if (state == ST_FORM) begin
      slope_num <= wide_s_t'(wide_t'(count) * wide_t'(sum_xy)
                             - wide_t'(sum_x) * wide_t'(sum_y));
      icpt_num  <= wide_s_t'(wide_t'(sum_y) * wide_t'(sum_xx)
                             - wide_t'(sum_x) * wide_t'(sum_xy));
      denom     <= wide_s_t'(wide_t'(count) * wide_t'(sum_xx)
                             - wide_t'(sum_x) * wide_t'(sum_x));
    end
    // result signs, kept while the dividers run
    if (div_start) begin
      slope_neg <= slope_num[DW-1] ^ denom[DW-1];
      icpt_neg  <= icpt_num[DW-1] ^ denom[DW-1];
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state         <= ST_IDLE;
      fit_valid     <= 1'b0;
      fit_error     <= 1'b0;
      sums_clear    <= 1'b0;
      fit_slope     <= '0;
      fit_intercept <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (tab_accept) begin
            state <= ST_FORM;
          end
        end
        ST_FORM: begin
          state <= ST_LAUNCH;
        end
        ST_LAUNCH: begin
          // vertical or empty set, nothing to divide
          if (denom_zero) begin
            fit_valid     <= 1'b1;
            fit_error     <= 1'b1;
            sums_clear    <= 1'b1;
            fit_slope     <= '0;
            fit_intercept <= '0;
            state         <= ST_REPORT;
          end else begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // both dividers started together, so they finish together
          if (slope_done && icpt_done) begin
            fit_slope     <= slope_neg ? -slope_t'(slope_q) : slope_t'(slope_q);
            fit_intercept <= icpt_neg ? -intercept_t'(icpt_q) : intercept_t'(icpt_q);
            fit_valid     <= 1'b1;
            fit_error     <= 1'b0;
            sums_clear    <= 1'b1;
            state         <= ST_REPORT;
          end
        end
        ST_REPORT: begin
          fit_valid     <= 1'b0;
          fit_error     <= 1'b0;
          sums_clear    <= 1'b0;
          fit_slope     <= '0;
          fit_intercept <= '0;
          state         <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // slope gets 8 fraction bits before the divide
  seq_divider #(.quot_t(slope_mag_t)) u_slope_div (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (div_start),
    .dividend (slope_abs << `FIT_SLOPE_FRAC),
    .divisor  (denom_abs),
    .done     (slope_done),
    .quotient (slope_q),
    .running  (slope_running)
  );

  seq_divider #(.quot_t(intercept_mag_t)) u_icpt_div (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (div_start),
    .dividend (icpt_abs),
    .divisor  (denom_abs),
    .done     (icpt_done),
    .quotient (icpt_q),
    .running  (icpt_running)
  );

  a_fit_valid_pulse: assert property (
    @(posedge clk_in) disable iff (rst_in)
    fit_valid |=> !fit_valid
  );

endmodule

`default_nettype wire

/* src/seq_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fit_defs.svh"

module seq_divider #(
  // only the low bits of the full quotient are returned
  parameter type quot_t = logic [`FIT_DIV_W-1:0]
) (
  input  wire logic                  clk_in,
  input  wire logic                  rst_in,
  input  wire logic                  start,
  input  wire logic [`FIT_DIV_W-1:0] dividend,
  input  wire logic [`FIT_DIV_W-1:0] divisor,
  output logic                       done,
  output quot_t                      quotient,
  output logic                       running
);

  localparam int DW = `FIT_DIV_W;
  localparam int CW = $clog2(DW + 1);

  // dividend bits shift out the top, quotient bits shift in the bottom
  logic [DW-1:0] work;
  logic [DW-1:0] rem;
  logic [DW-1:0] dsr;
  logic [CW-1:0] iter_left;
  // partial remainder with the next dividend bit, one spare bit
  logic [DW:0]   trial;
  logic [DW:0]   diff;
  logic          take;
  logic          load;

  assign load  = start && !running;
  assign trial = {rem, work[DW-1]};
  assign diff  = trial - {1'b0, dsr};
  // no borrow means divisor fits, quotient bit is 1
  assign take  = !diff[DW];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      running   <= 1'b0;
      done      <= 1'b0;
      iter_left <= '0;
    end else begin
      done <= 1'b0;
      if (load) begin
        running   <= 1'b1;
        iter_left <= CW'(DW);
      end else if (running) begin
        iter_left <= iter_left - CW'(1);
        // last bit lands on this edge
        if (iter_left == CW'(1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (load) begin
      work <= dividend;
      rem  <= '0;
      dsr  <= divisor;
    end else if (running) begin
      work <= {work[DW-2:0], take};
      // restore by keeping the unsubtracted value
      rem  <= take ? diff[DW-1:0] : trial[DW-1:0];
    end
  end

  assign quotient = quot_t'(work);

  // caller screens out a zero denominator
  a_divisor_nonzero: assert property (
    @(posedge clk_in) disable iff (rst_in)
    load |-> (divisor != '0)
  );

  a_done_single: assert property (
    @(posedge clk_in) disable iff (rst_in)
    done |=> !done
  );

endmodule

`default_nettype wire

/* src/moment_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module moment_accum
  import sample_pkg::*;
(
  input  wire logic    clk_in,
  input  wire logic    rst_in,
  input  wire logic    point_valid,
  input  wire x_t      point_x,
  input  wire y_t      point_y,
  // solver busy, points are dropped
  input  wire logic    hold,
  // zero all moments on the next edge
  input  wire logic    sums_clear,
  output count_t       count,
  output sum_x_t       sum_x,
  output sum_y_t       sum_y,
  output sum_xy_t      sum_xy,
  output sum_xx_t      sum_xx
);

  logic accept;

  // point taken only while the solver is idle
  assign accept = point_valid && !hold;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      count  <= '0;
      sum_x  <= '0;
      sum_y  <= '0;
      sum_xy <= '0;
      sum_xx <= '0;
    end else if (sums_clear) begin
      // fresh set after each reported fit
      count  <= '0;
      sum_x  <= '0;
      sum_y  <= '0;
      sum_xy <= '0;
      sum_xx <= '0;
    end else if (accept) begin
      count  <= count + count_t'(1);
      sum_x  <= sum_x + sum_x_t'(point_x);
      sum_y  <= sum_y + sum_y_t'(point_y);
      // operands widened first so the product keeps all bits
      sum_xy <= sum_xy + sum_xy_t'(point_x) * sum_xy_t'(point_y);
      sum_xx <= sum_xx + sum_xx_t'(point_x) * sum_xx_t'(point_x);
    end
  end

  // hold covers the report cycle, so a clear never meets a new point
  a_no_accept_on_clear: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(accept && sums_clear)
  );

endmodule

`default_nettype wire

/* src/fit_pkg.sv */
`default_nettype none

`include "fit_defs.svh"

package fit_pkg;

  // slope magnitude, integer part of y range plus fraction bits, 19 bits
  typedef logic [`FIT_Y_W+`FIT_SLOPE_FRAC:0] slope_mag_t;
  // intercept magnitude, up to 1023*2047, 22 bits
  typedef logic [`FIT_X_W+`FIT_Y_W:0] intercept_mag_t;

  // signed results, one extra bit for the sign
  // slope is fixed point, value/256
  typedef logic signed [`FIT_Y_W+`FIT_SLOPE_FRAC+1:0] slope_t;
  // intercept is a plain integer
  typedef logic signed [`FIT_X_W+`FIT_Y_W+1:0] intercept_t;

endpackage

`default_nettype wire

/* src/sample_pkg.sv */
`default_nettype none

`include "fit_defs.svh"

package sample_pkg;

  // one incoming point, unsigned pixel coordinates
  typedef logic [`FIT_X_W-1:0] x_t;
  typedef logic [`FIT_Y_W-1:0] y_t;

  // points collected so far
  typedef logic [`FIT_N_W-1:0] count_t;

  // moment sums, each wide enough for a full set at max coordinates
  // sum of x, 21 bits
  typedef logic [`FIT_X_W+`FIT_N_W-1:0] sum_x_t;
  // sum of y, 20 bits
  typedef logic [`FIT_Y_W+`FIT_N_W-1:0] sum_y_t;
  // sum of x*y, 31 bits
  typedef logic [`FIT_X_W+`FIT_Y_W+`FIT_N_W-1:0] sum_xy_t;
  // sum of x*x, 32 bits
  typedef logic [2*`FIT_X_W+`FIT_N_W-1:0] sum_xx_t;

endpackage

`default_nettype wire

/* src/fit_defs.svh */
`ifndef FIT_DEFS_SVH
`define FIT_DEFS_SVH

// pixel coordinate widths
// x spans a 2048 wide frame
`define FIT_X_W 11
// y spans 1024 rows
`define FIT_Y_W 10

// point counter, at most 1023 points in one set
`define FIT_N_W 10

// fixed point slope, 8 bits below the binary point
`define FIT_SLOPE_FRAC 8

// divider datapath width
// also the number of shift-subtract iterations
`define FIT_DIV_W 56

`endif
